// File: source/nes_state_defines.svh
`ifndef NES_STATE_DEFINES_SVH
`define NES_STATE_DEFINES_SVH

// CPU bus widths
`define CPU_ADDR_W    16
`define CPU_DATA_W    8

// State memory geometry
`define STATE_ADDR_W  9
`define STATE_DEPTH   512

// Width of the shadow OAM pointer, one full OAM page
`define OAM_ADDR_W    8

// Fixed state-memory slots, second write of a pair sits at base plus one
`define OFS_PPU_CTRL  9'h100
`define OFS_PPU_MASK  9'h101
`define OFS_OAM_ADDR  9'h102
`define OFS_SCROLL    9'h103
`define OFS_VRAM_ADDR 9'h105
`define OFS_APU_BASE  9'h107

`endif

// File: source/nes_state_pkg.sv
`default_nettype none

`include "nes_state_defines.svh"

package nes_state_pkg;

    // One CPU cycle as sampled on the bus
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
        logic                   rw;
    } bus_cycle_t;

    // Register event kinds seen by the execute stage
    typedef enum logic [2:0] {
        EV_NONE        = 3'd0,
        EV_PPU_DIRECT  = 3'd1,
        EV_OAM_ADDR    = 3'd2,
        EV_OAM_DATA    = 3'd3,
        EV_SCROLL      = 3'd4,
        EV_VRAM_ADDR   = 3'd5,
        EV_STATUS_READ = 3'd6,
        EV_APU         = 3'd7
    } reg_event_e;

    // Index carries the APU register number or the PPU select low bit
    typedef struct packed {
        reg_event_e             kind;
        logic [4:0]             index;
        logic [`CPU_DATA_W-1:0] data;
    } reg_event_t;

    typedef struct packed {
        logic                     we;
        logic [`STATE_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0]   data;
    } ram_write_t;

endpackage

`default_nettype wire

// File: source/cpu_bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_decoder (
    input  nes_state_pkg::bus_cycle_t bus,
    output nes_state_pkg::reg_event_t reg_event
);

    logic       is_ppu_range;
    logic       is_apu_range;
    logic [2:0] ppu_sel;

    // PPU registers repeat every 8 bytes across $2000-$3FFF
    assign is_ppu_range = (bus.addr[15:13] == 3'b001);
    // $4000-$4017 only, the $4018-$401F test block is not tracked
    assign is_apu_range = (bus.addr[15:5] == 11'h200) && (bus.addr[4:3] != 2'b11);
    assign ppu_sel      = bus.addr[2:0];

    always_comb begin
        reg_event.kind  = nes_state_pkg::EV_NONE;
        reg_event.index = '0;
        reg_event.data  = bus.data;

        if (bus.rw) begin
            // The only read with a side effect is $2002
            if (is_ppu_range && ppu_sel == 3'd2) begin
                reg_event.kind = nes_state_pkg::EV_STATUS_READ;
            end
        end else if (is_ppu_range) begin
            case (ppu_sel)
                3'd0, 3'd1: begin
                    reg_event.kind  = nes_state_pkg::EV_PPU_DIRECT;
                    reg_event.index = {4'b0000, ppu_sel[0]};
                end
                3'd3: begin
                    reg_event.kind = nes_state_pkg::EV_OAM_ADDR;
                end
                3'd4: begin
                    reg_event.kind = nes_state_pkg::EV_OAM_DATA;
                end
                3'd5: begin
                    reg_event.kind = nes_state_pkg::EV_SCROLL;
                end
                3'd6: begin
                    reg_event.kind = nes_state_pkg::EV_VRAM_ADDR;
                end
                // $2002 writes and the $2007 data port are not recorded
                default: begin
                    reg_event.kind = nes_state_pkg::EV_NONE;
                end
            endcase
        end else if (is_apu_range) begin
            reg_event.kind  = nes_state_pkg::EV_APU;
            reg_event.index = bus.addr[4:0];
        end
    end

endmodule

`default_nettype wire

// File: source/ppu_register_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "nes_state_defines.svh"

module ppu_register_tracker (
    input  logic                      m2,
    input  logic                      reset,
    input  nes_state_pkg::reg_event_t reg_event,
    output nes_state_pkg::ram_write_t wr
);

    logic [`OAM_ADDR_W-1:0]   oam_ptr;
    logic                     write_toggle;
    logic [`STATE_ADDR_W-1:0] toggle_ofs;
    logic [`STATE_ADDR_W-1:0] apu_ofs;

    assign toggle_ofs = {{(`STATE_ADDR_W-1){1'b0}}, write_toggle};
    assign apu_ofs    = {{(`STATE_ADDR_W-5){1'b0}}, reg_event.index};

    // Event to state-memory write, uses pointer and toggle before this edge
    always_comb begin
        wr.we   = 1'b0;
        wr.addr = '0;
        wr.data = reg_event.data;

        case (reg_event.kind)
            nes_state_pkg::EV_PPU_DIRECT: begin
                wr.we   = 1'b1;
                wr.addr = reg_event.index[0] ? `OFS_PPU_MASK : `OFS_PPU_CTRL;
            end
            nes_state_pkg::EV_OAM_ADDR: begin
                wr.we   = 1'b1;
                wr.addr = `OFS_OAM_ADDR;
            end
            nes_state_pkg::EV_OAM_DATA: begin
                wr.we   = 1'b1;
                wr.addr = {{(`STATE_ADDR_W-`OAM_ADDR_W){1'b0}}, oam_ptr};
            end
            nes_state_pkg::EV_SCROLL: begin
                wr.we   = 1'b1;
                wr.addr = `OFS_SCROLL + toggle_ofs;
            end
            nes_state_pkg::EV_VRAM_ADDR: begin
                wr.we   = 1'b1;
                wr.addr = `OFS_VRAM_ADDR + toggle_ofs;
            end
            nes_state_pkg::EV_APU: begin
                wr.we   = 1'b1;
                wr.addr = `OFS_APU_BASE + apu_ofs;
            end
            default: begin
                wr.we = 1'b0;
            end
        endcase

        // Nothing is recorded while the console is held in reset
        if (reset) begin
            wr.we = 1'b0;
        end
    end

    // Shadow of the PPU OAM address and the shared $2005/$2006 latch
    always_ff @(posedge m2) begin
        if (reset) begin
            oam_ptr      <= '0;
            write_toggle <= 1'b0;
        end else begin
            case (reg_event.kind)
                nes_state_pkg::EV_OAM_ADDR:    oam_ptr <= reg_event.data;
                // Wraps from 255 back to 0 by width
                nes_state_pkg::EV_OAM_DATA:    oam_ptr <= oam_ptr + 1'b1;
                nes_state_pkg::EV_SCROLL,
                nes_state_pkg::EV_VRAM_ADDR:   write_toggle <= ~write_toggle;
                nes_state_pkg::EV_STATUS_READ: write_toggle <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/state_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "nes_state_defines.svh"

module state_ram (
    input  logic                      m2,
    input  nes_state_pkg::ram_write_t wr,
    input  logic [`STATE_ADDR_W-1:0]  read_addr,
    output logic [`CPU_DATA_W-1:0]    read_data
);

    logic [`CPU_DATA_W-1:0] memory [`STATE_DEPTH];

    // Start from a blank state so a readout before any traffic gives zeros
    initial begin
        for (int i = 0; i < `STATE_DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    // Read returns the byte held before a same-edge write
    always_ff @(posedge m2) begin
        if (wr.we) begin
            memory[wr.addr] <= wr.data;
        end
        read_data <= memory[read_addr];
    end

endmodule

`default_nettype wire

// File: source/state_recorder.sv
`timescale 1ns/10ps
`default_nettype none

`include "nes_state_defines.svh"

module state_recorder (
    input  logic                     reset,

    // Bus monitor inputs, one cycle per m2 period
    input  logic                     m2,
    input  logic [`CPU_ADDR_W-1:0]   cpu_addr,
    input  logic [`CPU_DATA_W-1:0]   cpu_data,
    input  logic                     cpu_rw,

    // Host readout
    input  logic [`STATE_ADDR_W-1:0] read_addr,
    output logic [`CPU_DATA_W-1:0]   read_data
);

    nes_state_pkg::bus_cycle_t bus;
    nes_state_pkg::reg_event_t reg_event;
    nes_state_pkg::ram_write_t wr;

    assign bus = '{addr: cpu_addr, data: cpu_data, rw: cpu_rw};

    // Decode stage
    cpu_bus_decoder u_decoder (
        .bus       (bus),
        .reg_event (reg_event)
    );

    // Execute stage
    ppu_register_tracker u_tracker (
        .m2        (m2),
        .reset     (reset),
        .reg_event (reg_event),
        .wr        (wr)
    );

    // Result stage, second port serves readout
    state_ram u_ram (
        .m2        (m2),
        .wr        (wr),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

`default_nettype wire

// File: dv/state_recorder_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "nes_state_defines.svh"

module state_recorder_checker (
    input logic                      m2,
    input logic                      reset,
    input nes_state_pkg::reg_event_t reg_event,
    input nes_state_pkg::ram_write_t wr,
    input logic [`OAM_ADDR_W-1:0]    oam_ptr,
    input logic                      write_toggle
);

    // Sticky flag set by any failing assertion
    logic assert_failed = 1'b0;

    no_write_in_reset: assert property (@(posedge m2) reset |-> !wr.we)
        else begin
            assert_failed = 1'b1;
            $error("state memory write enabled while reset is high");
        end

    // $2002 read clears the shared $2005/$2006 latch
    status_clears_toggle: assert property (@(posedge m2) disable iff (reset)
        (reg_event.kind == nes_state_pkg::EV_STATUS_READ) |=> (write_toggle == 1'b0))
        else begin
            assert_failed = 1'b1;
            $error("write toggle not cleared after a status read");
        end

    // OAM data lands at the pointer held before the edge, which then steps by one
    oam_write_at_ptr: assert property (@(posedge m2) disable iff (reset)
        (wr.we && wr.addr < 9'h100) |=> (oam_ptr == 8'($past(wr.addr[7:0]) + 8'd1)))
        else begin
            assert_failed = 1'b1;
            $error("OAM write address differs from the OAM pointer");
        end

endmodule

bind state_recorder state_recorder_checker u_checker (
    .m2           (m2),
    .reset        (reset),
    .reg_event    (reg_event),
    .wr           (wr),
    .oam_ptr      (u_tracker.oam_ptr),
    .write_toggle (u_tracker.write_toggle)
);

`default_nettype wire

// File: dv/state_recorder_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "nes_state_defines.svh"

module state_recorder_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_CYCLES  = 3000;
    localparam int PLANNED_CYCLES = RESET_CYCLES + RANDOM_CYCLES + `STATE_DEPTH + 64;
    localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

    logic                     m2;
    logic                     reset;
    logic [`CPU_ADDR_W-1:0]   cpu_addr;
    logic [`CPU_DATA_W-1:0]   cpu_data;
    logic                     cpu_rw;
    logic [`STATE_ADDR_W-1:0] read_addr;
    logic [`CPU_DATA_W-1:0]   read_data;

    // Reset level applied together with the next bus cycle
    logic hold_reset;

    // Reference model of the shadow state
    logic [7:0] model_mem [`STATE_DEPTH];
    logic [7:0] model_ptr;
    logic       model_toggle;

    // Readout byte expected after the next rising edge
    logic       pending;
    logic [8:0] pending_addr;
    logic [7:0] pending_data;

    int cycle_count = 0;
    int fail_count  = 0;

    state_recorder dut (
        .reset     (reset),
        .m2        (m2),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .cpu_rw    (cpu_rw),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    initial begin
        m2 = 1'b0;
        forever #5 m2 = ~m2;
    end

    always @(posedge m2) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "cycle limit reached");
        end
    end

    always @(negedge m2) begin
        if (dut.u_checker.assert_failed) begin
            $display("An assertion in the bus checker failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input logic [7:0] expected, input logic [7:0] actual,
                               input string what);
        if (actual !== expected) begin
            fail_count++;
            $display("Error at %0t: %s expected 0x%02h got 0x%02h",
                     $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic model_update(input logic [15:0] addr, input logic [7:0] data,
                                input logic rw);
        if (rw) begin
            if (addr[15:13] == 3'b001 && addr[2:0] == 3'd2) begin
                model_toggle = 1'b0;
            end
        end else if (addr[15:13] == 3'b001) begin
            case (addr[2:0])
                3'd0: model_mem[`OFS_PPU_CTRL] = data;
                3'd1: model_mem[`OFS_PPU_MASK] = data;
                3'd3: begin
                    model_mem[`OFS_OAM_ADDR] = data;
                    model_ptr = data;
                end
                3'd4: begin
                    model_mem[{1'b0, model_ptr}] = data;
                    model_ptr = model_ptr + 8'd1;
                end
                3'd5: begin
                    model_mem[`OFS_SCROLL + {8'd0, model_toggle}] = data;
                    model_toggle = ~model_toggle;
                end
                3'd6: begin
                    model_mem[`OFS_VRAM_ADDR + {8'd0, model_toggle}] = data;
                    model_toggle = ~model_toggle;
                end
                default: ;
            endcase
        end else if (addr >= 16'h4000 && addr <= 16'h4017) begin
            model_mem[`OFS_APU_BASE + {4'd0, addr[4:0]}] = data;
        end
    endtask

    // One bus cycle plus one readout address driven on the falling edge
    task automatic run_cycle(input logic [15:0] addr, input logic [7:0] data,
                             input logic rw, input logic [8:0] raddr);
        @(negedge m2);
        if (pending) begin
            check_value(pending_data, read_data,
                        $sformatf("read_data for address 0x%03h", pending_addr));
        end
        reset     = hold_reset;
        cpu_addr  = addr;
        cpu_data  = data;
        cpu_rw    = rw;
        read_addr = raddr;
        // Read before write so the byte is taken before the model update
        pending      = 1'b1;
        pending_addr = raddr;
        pending_data = model_mem[raddr];
        if (reset) begin
            model_ptr    = 8'd0;
            model_toggle = 1'b0;
        end else begin
            model_update(addr, data, rw);
        end
    endtask

    task automatic random_cycle();
        logic [15:0] addr;
        logic [8:0]  raddr;
        int unsigned pick;
        pick = $urandom % 100;
        if (pick < 55) begin
            addr = {3'b001, 13'($urandom)};
        end else if (pick < 85) begin
            addr = {11'h200, 5'($urandom)};
        end else begin
            addr = 16'($urandom);
        end
        // Bias readout toward the register slots
        if ($urandom % 4 == 0) begin
            raddr = 9'h100 + 9'($urandom % 31);
        end else begin
            raddr = 9'($urandom);
        end
        run_cycle(addr, 8'($urandom), ($urandom % 100) < 15, raddr);
    endtask

    task automatic directed_cycles();
        // Pointer and toggle start at 0 after reset
        run_cycle(16'h2004, 8'hA5, 1'b0, 9'h000);
        run_cycle(16'h2005, 8'h3C, 1'b0, 9'h000);
        run_cycle(16'h0000, 8'h00, 1'b1, 9'h103);
        // Mirrors of $2000 and $2001 and a same-byte read showing the old value
        run_cycle(16'h3FF8, 8'h80, 1'b0, 9'h100);
        run_cycle(16'h2009, 8'h1E, 1'b0, 9'h100);
        run_cycle(16'h2007, 8'h55, 1'b0, 9'h101);
        // OAM pointer wraps from 0xFF to 0x00
        run_cycle(16'h2003, 8'hFD, 1'b0, 9'h102);
        for (int i = 0; i < 5; i++) begin
            // Each read picks up the OAM byte written one cycle earlier
            run_cycle(16'h2C04, 8'(8'h10 + i), 1'b0, {1'b0, 8'(8'hFC + i)});
        end
        // Shared toggle across $2005 and $2006 cleared by $2002
        run_cycle(16'h2005, 8'h01, 1'b0, 9'h104);
        run_cycle(16'h2006, 8'h02, 1'b0, 9'h105);
        run_cycle(16'h2002, 8'hFF, 1'b1, 9'h103);
        run_cycle(16'h2006, 8'h03, 1'b0, 9'h105);
        run_cycle(16'h3A0A, 8'h04, 1'b1, 9'h105);
        run_cycle(16'h2005, 8'h05, 1'b0, 9'h103);
        // APU range ends at $4017
        run_cycle(16'h4017, 8'h40, 1'b0, 9'h103);
        run_cycle(16'h4018, 8'h41, 1'b0, 9'h11E);
        run_cycle(16'h401F, 8'h42, 1'b0, 9'h11F);
    endtask

    initial begin
        reset      = 1'b1;
        hold_reset = 1'b1;
        cpu_addr   = '0;
        cpu_data   = '0;
        cpu_rw     = 1'b1;
        read_addr  = '0;
        pending    = 1'b0;
        model_ptr    = 8'd0;
        model_toggle = 1'b0;
        for (int i = 0; i < `STATE_DEPTH; i++) begin
            model_mem[i] = 8'h00;
        end
        void'($urandom(32));

        // Traffic during reset must not be recorded
        // Reset also covers the first edge, before any driven cycle
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            random_cycle();
        end
        hold_reset = 1'b0;

        directed_cycles();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_cycle();
        end

        // Full readout sweep with an idle bus
        for (int i = 0; i < `STATE_DEPTH; i++) begin
            run_cycle(16'h0000, 8'h00, 1'b1, 9'(i));
        end
        @(negedge m2);
        check_value(pending_data, read_data,
                    $sformatf("read_data for address 0x%03h", pending_addr));

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/nes_state_pkg.sv
source/cpu_bus_decoder.sv
source/ppu_register_tracker.sv
source/state_ram.sv
source/state_recorder.sv
dv/state_recorder_checker.sv
dv/state_recorder_tb.sv

// File: Makefile
# Verilator build and run for the bus state recorder

TOP := state_recorder_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f src.f --top-module $(TOP) -Mdir $(OBJ)

# Pass or fail is taken from the log
run: compile
	./$(OBJ)/V$(TOP) +verilator+error+limit+10 | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf $(OBJ) run.log
